//--- rtl/mem_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared memory bus definitions
// Widths, command encoding and transaction tag of the tagged memory bus
// used by the instruction cache and the data port
////////////////////////////////////////////////////////////////////////////

package mem_bus_pkg;

  // Bus widths
  localparam int unsigned ADDR_BITS = 64;
  localparam int unsigned DATA_BITS = 64;  // One full line per transfer
  localparam int unsigned TAG_BITS  = 4;

  // Byte address on the bus
  typedef logic [ADDR_BITS-1:0] mem_addr_t;

  // One memory line
  typedef logic [DATA_BITS-1:0] mem_data_t;

  // Transaction tag
  // Zero in a response means the command was refused
  typedef logic [TAG_BITS-1:0] mem_tag_t;

  // Bus command
  typedef enum logic [1:0]
  {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,  // Data returns later with the accepted tag
    BUS_STORE = 2'h2   // Done once accepted
  } bus_cmd_e;

endpackage

//--- rtl/fetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Fetch definitions
// Program counter, instruction word, instruction cache geometry and the
// credit constants of the instruction output
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  localparam int unsigned PC_BITS   = 64;
  localparam int unsigned INST_BITS = 32;

  typedef logic [PC_BITS-1:0]   pc_t;
  typedef logic [INST_BITS-1:0] inst_t;

  // Cache geometry
  localparam int unsigned CACHE_LINES      = 128;
  localparam int unsigned LINE_OFFSET_BITS = 3;  // 8 bytes per line
  localparam int unsigned INDEX_BITS       = $clog2(CACHE_LINES);
  localparam int unsigned TAG_LSB          = LINE_OFFSET_BITS + INDEX_BITS;

  typedef logic [INDEX_BITS-1:0]        cache_idx_t;
  typedef logic [PC_BITS-TAG_LSB-1:0]   cache_tag_t;  // 54 bits

  // Credits handed to fetch after reset
  localparam int unsigned FETCH_CREDITS = 4;

  typedef logic [2:0] credit_cnt_t;

  // Word held on the output at reset
  localparam inst_t NOOP_INST = 32'h47ff_041f;

  localparam pc_t RESET_PC = '0;

endpackage

//--- rtl/icache_mem.sv
////////////////////////////////////////////////////////////////////////////
// Instruction cache arrays
// Data, tag and valid storage of the 128 x 64 direct-mapped cache.
// One write port for fills and one combinational read port for lookup
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_mem
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   wr_en,
  input  fetch_pkg::cache_idx_t  wr_idx,
  input  fetch_pkg::cache_tag_t  wr_tag,
  input  mem_bus_pkg::mem_data_t wr_data,
  input  fetch_pkg::cache_idx_t  rd_idx,
  input  fetch_pkg::cache_tag_t  rd_tag,
  output mem_bus_pkg::mem_data_t rd_data,
  output logic                   rd_valid
);

  mem_bus_pkg::mem_data_t              data_mem [fetch_pkg::CACHE_LINES];
  fetch_pkg::cache_tag_t               tag_mem  [fetch_pkg::CACHE_LINES];
  logic [fetch_pkg::CACHE_LINES-1:0]   valid_bits;

  // Line and tag write on fill
  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

  // Valid bits, all cleared by reset
  always_ff @(posedge clock)
  begin
    if (reset)
      valid_bits <= '0;
    else if (wr_en)
      valid_bits[wr_idx] <= 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  assign rd_data  = data_mem[rd_idx];
  assign rd_valid = valid_bits[rd_idx] && (tag_mem[rd_idx] == rd_tag);  // Hit

endmodule

//--- rtl/icache_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Instruction cache controller
// Splits the fetch address, reports hits, requests missing lines on the
// memory bus and writes the line back when the tagged reply arrives.
// One miss is outstanding at a time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_ctrl
(
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::pc_t         fetch_addr,
  input  mem_bus_pkg::mem_data_t line_data,
  input  logic                   line_valid,
  input  mem_bus_pkg::mem_tag_t  mem_response,
  input  mem_bus_pkg::mem_data_t mem_rdata,
  input  mem_bus_pkg::mem_tag_t  mem_rtag,
  output fetch_pkg::cache_idx_t  rd_idx,
  output fetch_pkg::cache_tag_t  rd_tag,
  output logic                   fill_en,
  output fetch_pkg::cache_idx_t  fill_idx,
  output fetch_pkg::cache_tag_t  fill_tag,
  output mem_bus_pkg::mem_data_t fill_data,
  output mem_bus_pkg::bus_cmd_e  icache_command,
  output mem_bus_pkg::mem_addr_t icache_addr,
  output logic                   hit,
  output mem_bus_pkg::mem_data_t hit_line
);

  logic                   active;        // Out of reset for a cycle
  logic                   miss_pending;  // Line load accepted, data not back
  mem_bus_pkg::mem_tag_t  pend_tag;
  fetch_pkg::cache_idx_t  pend_idx;
  fetch_pkg::cache_tag_t  pend_ctag;
  logic                   req_held;      // Last request was refused
  mem_bus_pkg::mem_addr_t held_addr;
  mem_bus_pkg::mem_addr_t line_addr;
  logic                   req_accepted;

  // Address split for lookup
  assign rd_idx = fetch_addr[fetch_pkg::LINE_OFFSET_BITS +: fetch_pkg::INDEX_BITS];
  assign rd_tag = fetch_addr[fetch_pkg::PC_BITS-1:fetch_pkg::TAG_LSB];

  assign hit      = line_valid;
  assign hit_line = line_data;

  ////////////////////////////////////////////////////////////////////////////
  // Miss request
  ////////////////////////////////////////////////////////////////////////////

  // Line-aligned address of the current fetch
  assign line_addr = {fetch_addr[fetch_pkg::PC_BITS-1:fetch_pkg::LINE_OFFSET_BITS],
                      {fetch_pkg::LINE_OFFSET_BITS{1'b0}}};

  // Bus stays idle in reset and the cycle after
  // A refused request is repeated unchanged, even across a redirect
  assign icache_command = (active && !miss_pending && (req_held || !line_valid)) ?
                          mem_bus_pkg::BUS_LOAD : mem_bus_pkg::BUS_NONE;
  assign icache_addr    = req_held ? held_addr : line_addr;
  assign req_accepted   = (icache_command == mem_bus_pkg::BUS_LOAD) && (mem_response != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Fill
  ////////////////////////////////////////////////////////////////////////////

  // Matching reply fills its own line, whatever fetch does now
  assign fill_en   = miss_pending && (mem_rtag == pend_tag);
  assign fill_idx  = pend_idx;
  assign fill_tag  = pend_ctag;
  assign fill_data = mem_rdata;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      active       <= 1'b0;
      miss_pending <= 1'b0;
      req_held     <= 1'b0;
    end
    else
    begin
      active <= 1'b1;
      if (req_accepted)
        miss_pending <= 1'b1;
      else if (fill_en)
        miss_pending <= 1'b0;
      req_held <= (icache_command == mem_bus_pkg::BUS_LOAD) && !req_accepted;
    end
  end

  // Request bookkeeping
  always_ff @(posedge clock)
  begin
    if (req_accepted)
    begin
      pend_tag  <= mem_response;  // Tag named by the bus
      pend_idx  <= icache_addr[fetch_pkg::LINE_OFFSET_BITS +: fetch_pkg::INDEX_BITS];
      pend_ctag <= icache_addr[mem_bus_pkg::ADDR_BITS-1:fetch_pkg::TAG_LSB];
    end
    if ((icache_command == mem_bus_pkg::BUS_LOAD) && !req_accepted)
      held_addr <= icache_addr;
  end

endmodule

//--- rtl/dmem_port.sv
////////////////////////////////////////////////////////////////////////////
// Data memory port
// Takes one load or store from the data side, holds it on the bus until
// accepted and reports completion with a one-cycle done pulse
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dmem_port
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   data_req,
  input  logic                   data_we,
  input  mem_bus_pkg::mem_addr_t data_addr,
  input  mem_bus_pkg::mem_data_t data_wdata,
  input  mem_bus_pkg::mem_tag_t  mem_response,
  input  mem_bus_pkg::mem_data_t mem_rdata,
  input  mem_bus_pkg::mem_tag_t  mem_rtag,
  output logic                   data_ready,
  output logic                   data_done,
  output mem_bus_pkg::mem_data_t data_rdata,
  output mem_bus_pkg::bus_cmd_e  dmem_command,
  output mem_bus_pkg::mem_addr_t dmem_addr,
  output mem_bus_pkg::mem_data_t dmem_wdata
);

  typedef enum logic [1:0]
  {
    DMEM_IDLE,
    DMEM_REQ,   // Command on the bus
    DMEM_WAIT   // Load accepted, waiting for tagged data
  } dmem_state_e;

  dmem_state_e            state;
  logic                   req_we;
  mem_bus_pkg::mem_addr_t req_addr;
  mem_bus_pkg::mem_data_t req_wdata;
  mem_bus_pkg::mem_tag_t  req_tag;
  logic                   accepted;
  logic                   reply;

  assign data_ready   = (state == DMEM_IDLE);
  assign dmem_command = (state != DMEM_REQ) ? mem_bus_pkg::BUS_NONE :
                        req_we ? mem_bus_pkg::BUS_STORE : mem_bus_pkg::BUS_LOAD;
  assign dmem_addr    = req_addr;
  assign dmem_wdata   = req_wdata;

  assign accepted = (state == DMEM_REQ) && (mem_response != '0);
  assign reply    = (state == DMEM_WAIT) && (mem_rtag == req_tag);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state     <= DMEM_IDLE;
      data_done <= 1'b0;
    end
    else
    begin
      data_done <= (accepted && req_we) || reply;  // Store ends on acceptance
      case (state)
        DMEM_IDLE: if (data_req) state <= DMEM_REQ;
        DMEM_REQ:  if (accepted) state <= req_we ? DMEM_IDLE : DMEM_WAIT;
        DMEM_WAIT: if (reply)    state <= DMEM_IDLE;
        default:   state <= DMEM_IDLE;
      endcase
    end
  end

  // Request and reply payload
  always_ff @(posedge clock)
  begin
    if (data_req && data_ready)
    begin
      req_we    <= data_we;
      req_addr  <= data_addr;
      req_wdata <= data_wdata;
    end
    if (accepted)
      req_tag <= mem_response;
    if (reply)
      data_rdata <= mem_rdata;
  end

endmodule

//--- rtl/mem_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Memory bus arbiter
// Combinational owner select between data port and instruction cache,
// with priority to the data side. Acceptance goes only to the owner
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_arbiter
(
  input  mem_bus_pkg::bus_cmd_e  dmem_command,
  input  mem_bus_pkg::mem_addr_t dmem_addr,
  input  mem_bus_pkg::mem_data_t dmem_wdata,
  input  mem_bus_pkg::bus_cmd_e  icache_command,
  input  mem_bus_pkg::mem_addr_t icache_addr,
  input  mem_bus_pkg::mem_tag_t  mem_response,
  output mem_bus_pkg::bus_cmd_e  mem_command,
  output mem_bus_pkg::mem_addr_t mem_addr,
  output mem_bus_pkg::mem_data_t mem_wdata,
  output mem_bus_pkg::mem_tag_t  dmem_response,
  output mem_bus_pkg::mem_tag_t  icache_response
);

  logic dmem_owns;

  // Data side wins whenever it presents a command
  assign dmem_owns = (dmem_command != mem_bus_pkg::BUS_NONE);

  ////////////////////////////////////////////////////////////////////////////
  // Request mux
  ////////////////////////////////////////////////////////////////////////////

  assign mem_command = dmem_owns ? dmem_command : icache_command;
  assign mem_addr    = dmem_owns ? dmem_addr    : icache_addr;
  assign mem_wdata   = dmem_owns ? dmem_wdata   : '0;  // Cache only loads

  ////////////////////////////////////////////////////////////////////////////
  // Response steering
  ////////////////////////////////////////////////////////////////////////////

  // Loser sees zero and repeats next cycle
  assign dmem_response   = dmem_owns ? mem_response : '0;
  assign icache_response = dmem_owns ? '0 : mem_response;

endmodule

//--- rtl/fetch_unit.sv
////////////////////////////////////////////////////////////////////////////
// Fetch unit
// Program counter, redirect, credit count and the registered instruction
// output. One instruction per cycle on a hit while a credit is free
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_unit
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   hit,
  input  mem_bus_pkg::mem_data_t hit_line,
  input  logic                   credit_return,
  input  logic                   redirect,
  input  fetch_pkg::pc_t         redirect_pc,
  output fetch_pkg::pc_t         fetch_addr,
  output logic                   inst_valid,
  output fetch_pkg::inst_t       inst,
  output fetch_pkg::pc_t         inst_pc
);

  fetch_pkg::pc_t        pc;
  fetch_pkg::credit_cnt_t credits;   // Credit in use while inst_valid is high
  logic                  credit_free;
  logic                  fire;

  assign fetch_addr = pc;

  // Credit spent by the word now on the output is not free
  assign credit_free = (credits > fetch_pkg::credit_cnt_t'(inst_valid));
  assign fire        = hit && credit_free && !redirect;  // Redirect wins

  ////////////////////////////////////////////////////////////////////////////
  // Program counter and credits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc         <= fetch_pkg::RESET_PC;
      credits    <= fetch_pkg::credit_cnt_t'(fetch_pkg::FETCH_CREDITS);
      inst_valid <= 1'b0;
    end
    else
    begin
      credits    <= credits - fetch_pkg::credit_cnt_t'(inst_valid)
                            + fetch_pkg::credit_cnt_t'(credit_return);
      inst_valid <= fire;
      if (redirect)
        pc <= redirect_pc;
      else if (fire)
        pc <= pc + fetch_pkg::pc_t'(4);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      inst    <= fetch_pkg::NOOP_INST;
      inst_pc <= fetch_pkg::RESET_PC;
    end
    else if (fire)
    begin
      inst    <= pc[2] ? hit_line[63:32] : hit_line[31:0];  // Half by bit 2
      inst_pc <= pc;
    end
  end

endmodule

//--- rtl/frontend_top.sv
////////////////////////////////////////////////////////////////////////////
// Instruction front end top
// Fetch, instruction cache, data port and bus arbiter sharing one tagged
// memory bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frontend_top
(
  input  logic                   clock,
  input  logic                   reset,
  // Memory bus
  output mem_bus_pkg::bus_cmd_e  mem_command,
  output mem_bus_pkg::mem_addr_t mem_addr,
  output mem_bus_pkg::mem_data_t mem_wdata,
  input  mem_bus_pkg::mem_tag_t  mem_response,
  input  mem_bus_pkg::mem_data_t mem_rdata,
  input  mem_bus_pkg::mem_tag_t  mem_rtag,
  // Instruction stream
  output logic                   inst_valid,
  output fetch_pkg::inst_t       inst,
  output fetch_pkg::pc_t         inst_pc,
  input  logic                   credit_return,
  input  logic                   redirect,
  input  fetch_pkg::pc_t         redirect_pc,
  // Data side
  input  logic                   data_req,
  input  logic                   data_we,
  input  mem_bus_pkg::mem_addr_t data_addr,
  input  mem_bus_pkg::mem_data_t data_wdata,
  output logic                   data_ready,
  output logic                   data_done,
  output mem_bus_pkg::mem_data_t data_rdata
);

  fetch_pkg::pc_t         fetch_addr;
  logic                   hit, line_valid, fill_en;
  mem_bus_pkg::mem_data_t hit_line, line_data, fill_data;
  fetch_pkg::cache_idx_t  rd_idx, fill_idx;
  fetch_pkg::cache_tag_t  rd_tag, fill_tag;
  mem_bus_pkg::bus_cmd_e  icache_command, dmem_command;
  mem_bus_pkg::mem_addr_t icache_addr, dmem_addr;
  mem_bus_pkg::mem_data_t dmem_wdata;
  mem_bus_pkg::mem_tag_t  icache_response, dmem_response;

  fetch_unit u_fetch (.clock(clock), .reset(reset), .hit(hit), .hit_line(hit_line),
    .credit_return(credit_return), .redirect(redirect), .redirect_pc(redirect_pc),
    .fetch_addr(fetch_addr), .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc));

  icache_ctrl u_icache_ctrl (.clock(clock), .reset(reset), .fetch_addr(fetch_addr),
    .line_data(line_data), .line_valid(line_valid), .mem_response(icache_response),
    .mem_rdata(mem_rdata), .mem_rtag(mem_rtag), .rd_idx(rd_idx), .rd_tag(rd_tag),
    .fill_en(fill_en), .fill_idx(fill_idx), .fill_tag(fill_tag), .fill_data(fill_data),
    .icache_command(icache_command), .icache_addr(icache_addr), .hit(hit),
    .hit_line(hit_line));

  icache_mem u_icache_mem (.clock(clock), .reset(reset), .wr_en(fill_en),
    .wr_idx(fill_idx), .wr_tag(fill_tag), .wr_data(fill_data), .rd_idx(rd_idx),
    .rd_tag(rd_tag), .rd_data(line_data), .rd_valid(line_valid));

  dmem_port u_dmem (.clock(clock), .reset(reset), .data_req(data_req), .data_we(data_we),
    .data_addr(data_addr), .data_wdata(data_wdata), .mem_response(dmem_response),
    .mem_rdata(mem_rdata), .mem_rtag(mem_rtag), .data_ready(data_ready),
    .data_done(data_done), .data_rdata(data_rdata), .dmem_command(dmem_command),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata));

  // Data side has priority on the shared bus
  mem_arbiter u_arbiter (.dmem_command(dmem_command), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .icache_command(icache_command), .icache_addr(icache_addr),
    .mem_response(mem_response), .mem_command(mem_command), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .dmem_response(dmem_response),
    .icache_response(icache_response));

endmodule

//--- dv/frontend_checker.sv
////////////////////////////////////////////////////////////////////////////
// Front end protocol checker
// Concurrent assertions on the credit count and on repetition of refused
// bus commands by both bus peers, bound into the front end top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frontend_checker
(
  input logic                   clock,
  input logic                   reset,
  input logic                   inst_valid,
  input fetch_pkg::credit_cnt_t credits,
  input mem_bus_pkg::bus_cmd_e  icache_command,
  input mem_bus_pkg::mem_addr_t icache_addr,
  input mem_bus_pkg::mem_tag_t  icache_response,
  input mem_bus_pkg::bus_cmd_e  dmem_command,
  input mem_bus_pkg::mem_addr_t dmem_addr,
  input mem_bus_pkg::mem_tag_t  dmem_response
);

  int fail_count = 0;  // Failed assertions so far

  credit_bound: assert property (@(posedge clock) disable iff (reset)
    credits <= fetch_pkg::credit_cnt_t'(fetch_pkg::FETCH_CREDITS))
  else
  begin
    fail_count++;
    $error("Credit count above its reset value");
  end

  // Output needs a credit
  valid_with_credit: assert property (@(posedge clock) disable iff (reset)
    !(inst_valid && credits == '0))
  else
  begin
    fail_count++;
    $error("Instruction valid with no credit left");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Refused commands come back unchanged
  ////////////////////////////////////////////////////////////////////////////

  icache_retry: assert property (@(posedge clock) disable iff (reset)
    (icache_command == mem_bus_pkg::BUS_LOAD && icache_response == '0) |=>
    (icache_command == mem_bus_pkg::BUS_LOAD && icache_addr == $past(icache_addr)))
  else
  begin
    fail_count++;
    $error("Refused cache line load was not repeated");
  end

  dmem_retry: assert property (@(posedge clock) disable iff (reset)
    (dmem_command != mem_bus_pkg::BUS_NONE && dmem_response == '0) |=>
    (dmem_command == $past(dmem_command) && dmem_addr == $past(dmem_addr)))
  else
  begin
    fail_count++;
    $error("Refused data command was not repeated");
  end

endmodule

bind frontend_top frontend_checker u_checker
(
  .clock(clock), .reset(reset), .inst_valid(inst_valid), .credits(u_fetch.credits),
  .icache_command(icache_command), .icache_addr(icache_addr),
  .icache_response(icache_response), .dmem_command(dmem_command),
  .dmem_addr(dmem_addr), .dmem_response(dmem_response)
);

//--- dv/frontend_tb.sv
////////////////////////////////////////////////////////////////////////////
// Front end testbench
// Tagged memory model with random refusals, credit consumer that checks
// the instruction stream, and directed tests for fetch, back-pressure,
// redirect, the shared data port and cache reuse
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frontend_tb;

  localparam fetch_pkg::pc_t         JUMP_PC     = 64'h2200;  // Index 0x40, clear of low code
  localparam mem_bus_pkg::mem_addr_t DATA_ADDR   = 64'h0000_0040_0000_1008;
  localparam mem_bus_pkg::mem_data_t STORE_VALUE = 64'hc0ff_ee00_1234_5678;
  localparam fetch_pkg::pc_t         REUSE_END   = 64'h40;    // First 8 lines
  localparam int                     TIMEOUT     = 400;

  logic                   clock, reset;
  mem_bus_pkg::bus_cmd_e  mem_command;
  mem_bus_pkg::mem_addr_t mem_addr, data_addr;
  mem_bus_pkg::mem_data_t mem_wdata, mem_rdata, data_wdata, data_rdata;
  mem_bus_pkg::mem_tag_t  mem_response, mem_rtag;
  logic                   inst_valid, credit_return, redirect;
  logic                   data_req, data_we, data_ready, data_done;
  fetch_pkg::inst_t       inst;
  fetch_pkg::pc_t         inst_pc, redirect_pc;

  // Memory model state
  logic [31:0]            lfsr     = 32'h935c_7a26;
  mem_bus_pkg::mem_tag_t  next_tag = 4'h1;  // Rotates 1 to 15
  mem_bus_pkg::mem_data_t store_mem [mem_bus_pkg::mem_addr_t];
  mem_bus_pkg::mem_tag_t  ret_tag [$];
  mem_bus_pkg::mem_data_t ret_data [$];
  int                     ret_due [$];
  logic                   refuse, in_reset;
  int                     cycle = 0;

  // Consumer and scoreboard state
  fetch_pkg::pc_t expect_pc    = fetch_pkg::RESET_PC;
  int             inst_count   = 0;
  int             owed         = 0;  // Credits not yet handed back
  logic           hold_credits = 1'b0;
  logic           send_credit  = 1'b0;
  logic           watch_reuse  = 1'b0;
  int             reuse_loads  = 0;
  int             checks       = 0;
  int             errors       = 0;

  frontend_top uut (.clock(clock), .reset(reset), .mem_command(mem_command),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_response(mem_response),
    .mem_rdata(mem_rdata), .mem_rtag(mem_rtag), .inst_valid(inst_valid), .inst(inst),
    .inst_pc(inst_pc), .credit_return(credit_return), .redirect(redirect),
    .redirect_pc(redirect_pc), .data_req(data_req), .data_we(data_we),
    .data_addr(data_addr), .data_wdata(data_wdata), .data_ready(data_ready),
    .data_done(data_done), .data_rdata(data_rdata));

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Galois LFSR, one step per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // Instruction word at a byte address
  function automatic fetch_pkg::inst_t inst_word(input fetch_pkg::pc_t a);
    inst_word = (a[31:0] * 32'h0101_0003) ^ a[63:32] ^ 32'h1357_9bdf;
  endfunction

  // Line contents, stored data first
  function automatic mem_bus_pkg::mem_data_t read_line(input mem_bus_pkg::mem_addr_t a);
    if (store_mem.exists(a))
      read_line = store_mem[a];
    else
      read_line = {inst_word(a + 64'h4), inst_word(a)};
  endfunction

  task automatic compare_hex(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and credit return
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock)
  begin
    in_reset = reset;  // Value the DUT saw at this edge
    #1;
    cycle++;
    credit_return = send_credit;
    mem_rtag      = '0;
    if (ret_due.size() != 0 && ret_due[0] == cycle)
    begin
      mem_rtag  = ret_tag.pop_front();
      mem_rdata = ret_data.pop_front();
      void'(ret_due.pop_front());
    end
    mem_response = '0;
    if (!in_reset && mem_command != mem_bus_pkg::BUS_NONE)
    begin
      refuse = lfsr[0];
      lfsr   = lfsr_next(lfsr);
      refuse = refuse & lfsr[0];  // One in four refused
      lfsr   = lfsr_next(lfsr);
      if (!refuse)
      begin
        mem_response = next_tag;
        next_tag     = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
        if (mem_command == mem_bus_pkg::BUS_STORE)
          store_mem[mem_addr] = mem_wdata;  // Done on acceptance
        else
        begin
          ret_tag.push_back(mem_response);
          ret_data.push_back(read_line(mem_addr));
          ret_due.push_back(cycle + 3);
        end
      end
    end
  end

  // Consumer, sampled mid-cycle
  always @(negedge clock)
  begin
    if (!reset && inst_valid)
    begin
      compare_hex("inst_pc", inst_pc, expect_pc);
      compare_hex("inst", inst, inst_word(expect_pc));
      expect_pc = inst_pc + 64'h4;  // Resync so one slip reports once
      inst_count++;
      owed++;
    end
    if (redirect)
      expect_pc = redirect_pc;  // New stream from next cycle
    if (watch_reuse && mem_command == mem_bus_pkg::BUS_LOAD && mem_addr < REUSE_END)
      reuse_loads++;
    send_credit = !hold_credits && owed > 0;
    if (send_credit)
      owed--;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_for_insts(input int n);
    int target;
    int t;
    target = inst_count + n;
    t      = 0;
    while (inst_count < target && t < TIMEOUT)
    begin
      @(posedge clock);
      #1;
      t++;
    end
    if (inst_count < target)
    begin
      errors++;
      $display("Timed out waiting for %0d instructions", n);
    end
  endtask

  // One load or store through the data side, returns after data_done
  task automatic data_access(input logic we, input mem_bus_pkg::mem_addr_t addr,
                             input mem_bus_pkg::mem_data_t wdata);
    int t;
    t = 0;
    while (!data_ready && t < TIMEOUT)
    begin
      @(posedge clock);
      #1;
      t++;
    end
    if (!data_ready)
    begin
      errors++;
      $display("Timed out waiting for the data side to be ready");
    end
    data_req   = 1'b1;
    data_we    = we;
    data_addr  = addr;
    data_wdata = wdata;
    @(posedge clock);
    #1;
    data_req = 1'b0;
    t        = 0;
    while (!data_done && t < TIMEOUT)
    begin
      @(posedge clock);
      #1;
      t++;
    end
    if (!data_done)
    begin
      errors++;
      $display("Timed out waiting for the data side to finish");
    end
  endtask

  task automatic jump_to(input fetch_pkg::pc_t pc);
    redirect    = 1'b1;
    redirect_pc = pc;
    @(posedge clock);
    #1;
    redirect = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    compare_hex("inst_valid", inst_valid, 1'b0);
    compare_hex("data_done", data_done, 1'b0);
    compare_hex("data_ready", data_ready, 1'b1);
    compare_hex("mem_command", mem_command, mem_bus_pkg::BUS_NONE);
  endtask

  task automatic fetch_in_order();
    wait_for_insts(24);  // Stream checked by the consumer
  endtask

  task automatic hold_back_credits();
    int start;
    hold_credits = 1'b1;
    start        = inst_count;
    repeat (30) @(posedge clock);
    #1;
    if (inst_count - start > fetch_pkg::FETCH_CREDITS)
    begin
      errors++;
      $display("Error: instructions without credit = %h, limit %h",
               inst_count - start, fetch_pkg::FETCH_CREDITS);
    end
    hold_credits = 1'b0;
    wait_for_insts(12);  // No gap or repeat after release
  endtask

  task automatic redirect_stream();
    jump_to(JUMP_PC);
    wait_for_insts(20);
  endtask

  task automatic store_then_load();
    data_access(1'b1, DATA_ADDR, STORE_VALUE);
    data_access(1'b0, DATA_ADDR, '0);
    compare_hex("data_rdata", data_rdata, STORE_VALUE);
    wait_for_insts(8);  // Fetch still alive
  endtask

  task automatic refetch_cached_range();
    reuse_loads = 0;
    watch_reuse = 1'b1;
    jump_to(fetch_pkg::RESET_PC);
    wait_for_insts(16);
    watch_reuse = 1'b0;
    compare_hex("mem_addr loads to cached lines", reuse_loads, 0);
  endtask

  initial
  begin
    reset         = 1'b1;
    credit_return = 1'b0;
    redirect      = 1'b0;
    redirect_pc   = '0;
    data_req      = 1'b0;
    data_we       = 1'b0;
    data_addr     = '0;
    data_wdata    = '0;
    mem_response  = '0;
    mem_rdata     = '0;
    mem_rtag      = '0;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;
    check_reset_state();
    fetch_in_order();
    hold_back_credits();
    redirect_stream();
    store_then_load();
    refetch_cached_range();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, uut.u_checker.fail_count);
    if (errors == 0 && uut.u_checker.fail_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- filelist.f
rtl/mem_bus_pkg.sv
rtl/fetch_pkg.sv
rtl/icache_mem.sv
rtl/icache_ctrl.sv
rtl/dmem_port.sv
rtl/mem_arbiter.sv
rtl/fetch_unit.sv
rtl/frontend_top.sv
dv/frontend_checker.sv
dv/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend

sources:
  # Packages first
  - rtl/mem_bus_pkg.sv
  - rtl/fetch_pkg.sv
  # Design
  - rtl/icache_mem.sv
  - rtl/icache_ctrl.sv
  - rtl/dmem_port.sv
  - rtl/mem_arbiter.sv
  - rtl/fetch_unit.sv
  - rtl/frontend_top.sv
  # Testbench
  - target: test
    files:
      - dv/frontend_checker.sv
      - dv/frontend_tb.sv
